//--- logic/spindle_pkg.sv
package spindle_pkg;

    ////////////////////
    // widths

    localparam int word_w     = 32;  // parameter and data words
    localparam int rate_shift = 8;   // fixed-point shift of the spindle products

    ////////////////////
    // parameter trigger bits, also the readback addresses

    localparam int addr_gamma_dyn = 1;
    localparam int addr_gamma_sta = 2;
    localparam int addr_len_mode  = 3;  // 0 = length from serial link
    localparam int addr_host_len  = 4;
    localparam int addr_lce_rest  = 5;
    localparam int addr_tick_half = 6;

    ////////////////////
    // reset values

    localparam logic [word_w-1:0] rst_gamma_dyn = 32'd80;
    localparam logic [word_w-1:0] rst_gamma_sta = 32'd80;
    localparam logic [word_w-1:0] rst_len_mode  = 32'd0;
    localparam logic [word_w-1:0] rst_host_len  = 32'd1200;
    localparam logic [word_w-1:0] rst_lce_rest  = 32'd1000;  // resting length
    localparam logic [word_w-1:0] rst_tick_half = 32'd24;    // 25 cycles per tick

    // host writes two 16-bit halves, the model reads one 32-bit value
    typedef union packed {
        struct packed {
            logic [15:0] hi;
            logic [15:0] lo;
        } halves;
        logic [word_w-1:0] value;
    } param_word_t;

endpackage

//--- logic/param_bank.sv
module param_bank (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic [15:0]                       wire_hi,
    input  logic [15:0]                       wire_lo,
    input  logic [15:0]                       trig,
    input  logic [3:0]                        rd_addr,
    output spindle_pkg::param_word_t          rd_data,
    output logic [spindle_pkg::word_w-1:0]    gamma_dyn,
    output logic [spindle_pkg::word_w-1:0]    gamma_sta,
    output logic [spindle_pkg::word_w-1:0]    len_mode,
    output logic [spindle_pkg::word_w-1:0]    host_len,
    output logic [spindle_pkg::word_w-1:0]    lce_rest,
    output logic [spindle_pkg::word_w-1:0]    tick_half
);

    spindle_pkg::param_word_t load_word;

    // wire-in pair as seen by every register
    assign load_word.halves.hi = wire_hi;
    assign load_word.halves.lo = wire_lo;

    ////////////////////
    // trigger-loaded registers

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            gamma_dyn <= spindle_pkg::rst_gamma_dyn;
            gamma_sta <= spindle_pkg::rst_gamma_sta;
            len_mode  <= spindle_pkg::rst_len_mode;
            host_len  <= spindle_pkg::rst_host_len;
            lce_rest  <= spindle_pkg::rst_lce_rest;
            tick_half <= spindle_pkg::rst_tick_half;
        end else begin
            if (trig[spindle_pkg::addr_gamma_dyn])
                gamma_dyn <= load_word.value;
            if (trig[spindle_pkg::addr_gamma_sta])
                gamma_sta <= load_word.value;
            if (trig[spindle_pkg::addr_len_mode])
                len_mode <= load_word.value;
            if (trig[spindle_pkg::addr_host_len])
                host_len <= load_word.value;
            if (trig[spindle_pkg::addr_lce_rest])
                lce_rest <= load_word.value;
            if (trig[spindle_pkg::addr_tick_half])
                tick_half <= load_word.value;  // picked up at next tick restart
        end
    end

    ////////////////////
    // host readback

    always_comb begin
        case (rd_addr)
            4'(spindle_pkg::addr_gamma_dyn): rd_data.value = gamma_dyn;
            4'(spindle_pkg::addr_gamma_sta): rd_data.value = gamma_sta;
            4'(spindle_pkg::addr_len_mode):  rd_data.value = len_mode;
            4'(spindle_pkg::addr_host_len):  rd_data.value = host_len;
            4'(spindle_pkg::addr_lce_rest):  rd_data.value = lce_rest;
            4'(spindle_pkg::addr_tick_half): rd_data.value = tick_half;
            default:                         rd_data.value = '0;  // unused address
        endcase
    end

endmodule

//--- logic/tick_divider.sv
module tick_divider (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic [spindle_pkg::word_w-1:0]    tick_half,
    output logic                              sim_tick
);

    logic [spindle_pkg::word_w-1:0] tick_cnt;
    logic [spindle_pkg::word_w-1:0] tick_limit;  // tick_half held for one period

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            tick_cnt   <= '0;
            tick_limit <= spindle_pkg::rst_tick_half;
            sim_tick   <= 1'b0;
        end else if (tick_cnt == tick_limit) begin
            // restart, new limit only here
            tick_cnt   <= '0;
            tick_limit <= tick_half;
            sim_tick   <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            sim_tick <= 1'b0;
        end
    end

endmodule

//--- logic/spi_length_receiver.sv
module spi_length_receiver (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic                              spi_in_sck,
    input  logic                              spi_in_mosi,
    input  logic                              spi_in_ssel,
    output logic [spindle_pkg::word_w-1:0]    rx_word,
    output logic                              frame_valid
);

    logic [2:0] sck_q;   // two sync flops plus edge history
    logic [2:0] ssel_q;
    logic [1:0] mosi_q;
    logic [5:0] bit_cnt;  // saturates, only 32 means a good frame
    logic [spindle_pkg::word_w-1:0] shift_reg;
    logic sck_rise;
    logic ssel_rise;
    logic frame_active;

    assign sck_rise     = sck_q[1] & ~sck_q[2];
    assign ssel_rise    = ssel_q[1] & ~ssel_q[2];
    assign frame_active = ~ssel_q[1];

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            sck_q       <= '0;
            ssel_q      <= '1;  // bus idle
            mosi_q      <= '0;
            bit_cnt     <= '0;
            rx_word     <= '0;
            frame_valid <= 1'b0;
        end else begin
            sck_q       <= {sck_q[1:0], spi_in_sck};
            ssel_q      <= {ssel_q[1:0], spi_in_ssel};
            mosi_q      <= {mosi_q[0], spi_in_mosi};
            frame_valid <= 1'b0;
            if (ssel_rise) begin
                if (bit_cnt == 6'd32) begin
                    rx_word     <= shift_reg;
                    frame_valid <= 1'b1;
                end
                bit_cnt <= '0;  // short or long frames are dropped
            end else if (frame_active && sck_rise && bit_cnt != 6'd63) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // msb first
    always_ff @(posedge ep50trig) begin
        if (frame_active && sck_rise)
            shift_reg <= {shift_reg[spindle_pkg::word_w-2:0], mosi_q[1]};
    end

endmodule

//--- logic/spi_rate_sender.sv
module spi_rate_sender #(
    parameter int spi_div = 2  // clocks per sck half-period
) (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic                              sim_tick,
    input  logic [spindle_pkg::word_w-1:0]    rate_ia,
    output logic                              spi_out_sck,
    output logic                              spi_out_mosi,
    output logic                              spi_out_ssel
);

    localparam int div_w = (spi_div > 1) ? $clog2(spi_div) : 1;
    localparam logic [div_w-1:0] div_last = div_w'(spi_div - 1);
    localparam logic st_idle  = 1'b0;
    localparam logic st_shift = 1'b1;

    logic state;
    logic [div_w-1:0] div_cnt;
    logic [4:0] bit_cnt;
    logic [spindle_pkg::word_w-1:0] shift_reg;
    logic half_done;
    logic start;

    assign half_done = (div_cnt == div_last);
    assign start     = (state == st_idle) && sim_tick;  // busy ticks dropped

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            state        <= st_idle;
            div_cnt      <= '0;
            bit_cnt      <= '0;
            spi_out_sck  <= 1'b0;
            spi_out_ssel <= 1'b1;
            spi_out_mosi <= 1'b0;
        end else if (start) begin
            state        <= st_shift;
            div_cnt      <= '0;
            bit_cnt      <= '0;
            spi_out_ssel <= 1'b0;
            spi_out_mosi <= rate_ia[spindle_pkg::word_w-1];  // first bit ready before sck
        end else if (state == st_shift) begin
            if (!half_done) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                spi_out_sck <= ~spi_out_sck;
                if (spi_out_sck) begin
                    // falling edge, next bit or end of frame
                    if (bit_cnt == 5'd31) begin
                        state        <= st_idle;
                        spi_out_ssel <= 1'b1;
                        spi_out_mosi <= 1'b0;
                    end else begin
                        bit_cnt      <= bit_cnt + 1'b1;
                        spi_out_mosi <= shift_reg[spindle_pkg::word_w-2];
                    end
                end
            end
        end
    end

    always_ff @(posedge ep50trig) begin
        if (start)
            shift_reg <= rate_ia;
        else if (state == st_shift && half_done && spi_out_sck)
            shift_reg <= shift_reg << 1;
    end

endmodule

//--- logic/spindle_afferent.sv
module spindle_afferent (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic                              sim_tick,
    input  logic [spindle_pkg::word_w-1:0]    muscle_len,
    input  logic [spindle_pkg::word_w-1:0]    gamma_dyn,
    input  logic [spindle_pkg::word_w-1:0]    gamma_sta,
    input  logic [spindle_pkg::word_w-1:0]    lce_rest,
    output logic [spindle_pkg::word_w-1:0]    rate_ia,
    output logic [spindle_pkg::word_w-1:0]    rate_ii
);

    localparam int ww = spindle_pkg::word_w;

    logic [ww-1:0] prev_len;                // length at the previous tick
    logic signed [ww-1:0] diff_sta;
    logic signed [ww-1:0] diff_dyn;
    logic signed [2*ww-1:0] prod_sta;
    logic signed [2*ww-1:0] prod_dyn;
    logic signed [ww-1:0] term_sta;
    logic signed [ww-1:0] term_dyn;
    logic signed [ww-1:0] term_sum;
    logic stage1_valid;

    assign diff_sta = muscle_len - lce_rest;
    assign diff_dyn = muscle_len - prev_len;
    assign prod_sta = $signed(gamma_sta) * diff_sta;
    assign prod_dyn = $signed(gamma_dyn) * diff_dyn;
    assign term_sum = term_sta + term_dyn;

    ////////////////////
    // stage 1, scaled terms

    always_ff @(posedge ep50trig) begin
        if (sim_tick) begin
            term_sta <= prod_sta[spindle_pkg::rate_shift +: ww];  // arithmetic shift
            term_dyn <= prod_dyn[spindle_pkg::rate_shift +: ww];
        end
    end

    ////////////////////
    // stage 2, rates clamped at zero

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            prev_len     <= '0;
            stage1_valid <= 1'b0;
            rate_ia      <= '0;
            rate_ii      <= '0;
        end else begin
            stage1_valid <= sim_tick;
            if (sim_tick)
                prev_len <= muscle_len;
            if (stage1_valid) begin
                rate_ii <= term_sta[ww-1] ? '0 : term_sta;
                rate_ia <= term_sum[ww-1] ? '0 : term_sum;
            end
        end
    end

endmodule

//--- logic/spindle_board.sv
module spindle_board #(
    parameter int spi_div = 2
) (
    input  logic                              ep50trig,
    input  logic                              reset_global,
    input  logic [15:0]                       wire_hi,
    input  logic [15:0]                       wire_lo,
    input  logic [15:0]                       trig,
    input  logic [3:0]                        rd_addr,
    output logic [spindle_pkg::word_w-1:0]    rd_data,
    input  logic                              spi_in_sck,
    input  logic                              spi_in_mosi,
    input  logic                              spi_in_ssel,
    output logic                              spi_out_sck,
    output logic                              spi_out_mosi,
    output logic                              spi_out_ssel,
    output logic [spindle_pkg::word_w-1:0]    muscle_len,
    output logic [spindle_pkg::word_w-1:0]    rate_ia,
    output logic [spindle_pkg::word_w-1:0]    rate_ii,
    output logic                              sim_tick
);

    spindle_pkg::param_word_t bank_rd;
    logic [spindle_pkg::word_w-1:0] gamma_dyn, gamma_sta, len_mode;
    logic [spindle_pkg::word_w-1:0] host_len, lce_rest, tick_half;
    logic [spindle_pkg::word_w-1:0] rx_word;
    logic frame_valid;
    logic src_host;  // muscle_len came from host_len last cycle

    assign rd_data = bank_rd.value;

    param_bank params_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .wire_hi(wire_hi), .wire_lo(wire_lo), .trig(trig),
        .rd_addr(rd_addr), .rd_data(bank_rd),
        .gamma_dyn(gamma_dyn), .gamma_sta(gamma_sta), .len_mode(len_mode),
        .host_len(host_len), .lce_rest(lce_rest), .tick_half(tick_half)
    );

    tick_divider ticks_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .tick_half(tick_half), .sim_tick(sim_tick)
    );

    spi_length_receiver len_rx_i (
        .ep50trig(ep50trig), .reset_global(reset_global),
        .spi_in_sck(spi_in_sck), .spi_in_mosi(spi_in_mosi), .spi_in_ssel(spi_in_ssel),
        .rx_word(rx_word), .frame_valid(frame_valid)
    );

    // length source, rx_word only moves with frame_valid
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            muscle_len <= '0;
            src_host   <= 1'b0;
        end else begin
            src_host <= (len_mode != '0);
            if (len_mode != '0)
                muscle_len <= host_len;
            else if (frame_valid || src_host)
                muscle_len <= rx_word;
        end
    end

    spindle_afferent spindle_i (
        .ep50trig(ep50trig), .reset_global(reset_global), .sim_tick(sim_tick),
        .muscle_len(muscle_len), .gamma_dyn(gamma_dyn), .gamma_sta(gamma_sta),
        .lce_rest(lce_rest), .rate_ia(rate_ia), .rate_ii(rate_ii)
    );

    spi_rate_sender #(.spi_div(spi_div)) rate_tx_i (
        .ep50trig(ep50trig), .reset_global(reset_global), .sim_tick(sim_tick),
        .rate_ia(rate_ia), .spi_out_sck(spi_out_sck), .spi_out_mosi(spi_out_mosi),
        .spi_out_ssel(spi_out_ssel)
    );

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 3
) (
    output logic ep50trig,
    output logic reset_global
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        ep50trig = 1'b0;
        forever #(period_ns / 2) ep50trig = ~ep50trig;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset_global = 1'b1;
        repeat (reset_cycles) @(posedge ep50trig);
        @(negedge ep50trig);
        reset_global = 1'b0;
    end

endmodule

//--- tb/spindle_board_checker.sv
module spindle_board_checker (
    input logic        ep50trig,
    input logic        reset_global,
    input logic [15:0] wire_hi,
    input logic [15:0] wire_lo,
    input logic [15:0] trig,
    input logic [3:0]  rd_addr,
    input logic [31:0] rd_data,
    input logic [31:0] tick_half,
    input logic [31:0] len_mode,
    input logic [31:0] host_len,
    input logic [31:0] lce_rest,
    input logic [31:0] gamma_dyn,
    input logic [31:0] gamma_sta,
    input logic        sim_tick,
    input logic [31:0] muscle_len,
    input logic [31:0] rate_ia,
    input logic [31:0] rate_ii,
    input logic        spi_in_sck,
    input logic        spi_in_mosi,
    input logic        spi_in_ssel,
    input logic        spi_out_sck,
    input logic        spi_out_mosi,
    input logic        spi_out_ssel
);

    timeunit 1ns;
    timeprecision 1ps;

    int err_cnt = 0;
    logic trig_seen;
    logic tick_seen;
    logic [31:0] tick_gap, half_prev, expect_half;
    logic [31:0] prev_len;
    logic in_sck_d, out_sck_d, out_ssel_d;
    int rx_bits, tx_bits;
    logic [31:0] rx_word, tx_word, tx_expect, rate_ia_d;
    longint p_sta, p_dyn;
    logic signed [31:0] t_sta, t_dyn, t_sum;
    logic [31:0] exp_ia, exp_ii;

    function automatic logic [31:0] reset_value(input logic [3:0] addr);
        case (addr)
            4'(spindle_pkg::addr_gamma_dyn): return spindle_pkg::rst_gamma_dyn;
            4'(spindle_pkg::addr_gamma_sta): return spindle_pkg::rst_gamma_sta;
            4'(spindle_pkg::addr_len_mode):  return spindle_pkg::rst_len_mode;
            4'(spindle_pkg::addr_host_len):  return spindle_pkg::rst_host_len;
            4'(spindle_pkg::addr_lce_rest):  return spindle_pkg::rst_lce_rest;
            default:                         return spindle_pkg::rst_tick_half;
        endcase
    endfunction

    ////////////////////
    // reference model of the spindle formula
    always_comb begin
        p_sta = longint'($signed(gamma_sta)) * longint'($signed(32'(muscle_len - lce_rest)));
        p_dyn = longint'($signed(gamma_dyn)) * longint'($signed(32'(muscle_len - prev_len)));
        t_sta = 32'(p_sta >>> spindle_pkg::rate_shift);
        t_dyn = 32'(p_dyn >>> spindle_pkg::rate_shift);
        t_sum = t_sta + t_dyn;
        exp_ii = (t_sta < 0) ? 32'd0 : t_sta;
        exp_ia = (t_sum < 0) ? 32'd0 : t_sum;
    end

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            trig_seen <= 1'b0;
            tick_seen <= 1'b0;
            tick_gap <= '0;
            half_prev <= spindle_pkg::rst_tick_half;
            expect_half <= spindle_pkg::rst_tick_half;
            prev_len <= '0;
            in_sck_d <= 1'b0;
            out_sck_d <= 1'b0;
            out_ssel_d <= 1'b1;
            rx_bits <= 0;
            tx_bits <= 0;
            rx_word <= '0;
            tx_word <= '0;
            tx_expect <= '0;
            rate_ia_d <= '0;
        end else begin
            if (trig != '0)
                trig_seen <= 1'b1;
            half_prev <= tick_half;
            tick_gap <= sim_tick ? 32'd1 : tick_gap + 1;
            if (sim_tick) begin
                tick_seen <= 1'b1;
                expect_half <= half_prev;  // limit taken at the restart edge
                prev_len <= muscle_len;
            end
            in_sck_d <= spi_in_sck;
            if (spi_in_ssel) begin
                rx_bits <= 0;
            end else if (spi_in_sck && !in_sck_d) begin
                rx_bits <= rx_bits + 1;
                rx_word <= {rx_word[30:0], spi_in_mosi};
            end
            rate_ia_d <= rate_ia;
            out_sck_d <= spi_out_sck;
            out_ssel_d <= spi_out_ssel;
            if (!spi_out_ssel && out_ssel_d) begin
                tx_expect <= rate_ia_d;  // word latched at the tick edge
                tx_bits <= 0;
            end else if (!spi_out_ssel && spi_out_sck && !out_sck_d) begin
                tx_bits <= tx_bits + 1;
                tx_word <= {tx_word[30:0], spi_out_mosi};
            end
        end
    end

    ////////////////////
    // assertions
    a_reset_vals: assert property (@(posedge ep50trig) disable iff (reset_global)
        (!trig_seen && rd_addr >= 4'd1 && rd_addr <= 4'd6) |-> rd_data == reset_value(rd_addr))
        else begin
            err_cnt++;
            $error("ERROR rd_data=%h expected %h", rd_data, reset_value(rd_addr));
        end

    a_trig_load: assert property (@(posedge ep50trig) disable iff (reset_global)
        (rd_addr >= 4'd1 && rd_addr <= 4'd6 && trig[rd_addr])
            |=> rd_data == $past({wire_hi, wire_lo}))
        else begin
            err_cnt++;
            $error("ERROR rd_data=%h expected %h after trigger",
                   rd_data, $past({wire_hi, wire_lo}));
        end

    a_tick_gap: assert property (@(posedge ep50trig) disable iff (reset_global)
        (sim_tick && tick_seen) |-> tick_gap == expect_half + 1)
        else begin
            err_cnt++;
            $error("ERROR tick gap=%h expected %h", tick_gap, expect_half + 1);
        end

    a_frame_len: assert property (@(posedge ep50trig) disable iff (reset_global)
        ($rose(spi_in_ssel) && len_mode == 0 && rx_bits == 32)
            |-> ##4 muscle_len == $past(rx_word, 4))
        else begin
            err_cnt++;
            $error("ERROR muscle_len=%h expected %h after full frame",
                   muscle_len, $past(rx_word, 4));
        end

    a_short_frame: assert property (@(posedge ep50trig) disable iff (reset_global)
        ($rose(spi_in_ssel) && len_mode == 0 && rx_bits != 32)
            |-> ##4 muscle_len == $past(muscle_len, 4))
        else begin
            err_cnt++;
            $error("ERROR muscle_len=%h expected %h after short frame",
                   muscle_len, $past(muscle_len, 4));
        end

    a_host_len: assert property (@(posedge ep50trig) disable iff (reset_global)
        (len_mode != 0) |=> muscle_len == $past(host_len))
        else begin
            err_cnt++;
            $error("ERROR muscle_len=%h expected host_len=%h", muscle_len, $past(host_len));
        end

    a_rates: assert property (@(posedge ep50trig) disable iff (reset_global)
        sim_tick |-> ##2 (rate_ia == $past(exp_ia, 2) && rate_ii == $past(exp_ii, 2)))
        else begin
            err_cnt++;
            $error("ERROR rate_ia=%h rate_ii=%h expected %h %h",
                   rate_ia, rate_ii, $past(exp_ia, 2), $past(exp_ii, 2));
        end

    a_tx_word: assert property (@(posedge ep50trig) disable iff (reset_global)
        $rose(spi_out_ssel) |-> (tx_bits == 32 && tx_word == tx_expect))
        else begin
            err_cnt++;
            $error("ERROR spi_out word=%h expected %h", tx_word, tx_expect);
        end

    a_tx_bits: assert property (@(posedge ep50trig) disable iff (reset_global)
        !spi_out_ssel |-> tx_bits <= 32)  // no restart inside a frame
        else begin
            err_cnt++;
            $error("serial output frame longer than 32 bits");
        end

endmodule

bind spindle_board spindle_board_checker chk_i (
    .ep50trig(ep50trig), .reset_global(reset_global), .wire_hi(wire_hi),
    .wire_lo(wire_lo), .trig(trig), .rd_addr(rd_addr), .rd_data(rd_data),
    .tick_half(tick_half), .len_mode(len_mode), .host_len(host_len),
    .lce_rest(lce_rest), .gamma_dyn(gamma_dyn), .gamma_sta(gamma_sta),
    .sim_tick(sim_tick), .muscle_len(muscle_len), .rate_ia(rate_ia), .rate_ii(rate_ii),
    .spi_in_sck(spi_in_sck), .spi_in_mosi(spi_in_mosi), .spi_in_ssel(spi_in_ssel),
    .spi_out_sck(spi_out_sck), .spi_out_mosi(spi_out_mosi), .spi_out_ssel(spi_out_ssel)
);

//--- tb/spindle_board_tb.sv
module spindle_board_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic ep50trig, reset_global;
    logic [15:0] wire_hi, wire_lo, trig;
    logic [3:0] rd_addr;
    logic [31:0] rd_data, muscle_len, rate_ia, rate_ii;
    logic spi_in_sck, spi_in_mosi, spi_in_ssel;
    logic spi_out_sck, spi_out_mosi, spi_out_ssel, sim_tick;
    integer seed = 5;
    int timeouts = 0;
    int errs;

    tb_clock_gen clk_i (.ep50trig(ep50trig), .reset_global(reset_global));

    spindle_board #(.spi_div(2)) dut_i (.*);

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (reset_global && n < 100) begin
            @(negedge ep50trig);
            n++;
        end
        if (reset_global) begin
            timeouts++;
            $display("timeout while waiting for reset release");
        end
    endtask

    task automatic load_param(input int addr, input logic [31:0] value);
        @(negedge ep50trig);
        rd_addr = 4'(addr);  // stays here so the checker sees the load
        {wire_hi, wire_lo} = value;
        trig = 16'(1 << addr);
        @(negedge ep50trig);
        trig = '0;
        @(negedge ep50trig);
    endtask

    task automatic wait_ticks(input int count);
        int n;
        repeat (count) begin
            n = 0;
            do begin
                @(negedge ep50trig);
                n++;
            end while (!sim_tick && n < 2000);
            if (!sim_tick) begin
                timeouts++;
                $display("timeout while waiting for sim_tick");
            end
        end
    endtask

    task automatic wait_sender_idle();
        int n;
        n = 0;
        do begin
            @(negedge ep50trig);
            n++;
        end while (!spi_out_ssel && n < 2000);
        if (!spi_out_ssel) begin
            timeouts++;
            $display("timeout while waiting for the serial output to go idle");
        end
    endtask

    // msb first, data set while sck is low
    task automatic send_frame(input logic [31:0] word, input int nbits);
        @(negedge ep50trig);
        spi_in_ssel = 1'b0;
        repeat (2) @(negedge ep50trig);
        for (int i = 31; i > 31 - nbits; i--) begin
            spi_in_mosi = word[i];
            repeat (3) @(negedge ep50trig);
            spi_in_sck = 1'b1;
            repeat (3) @(negedge ep50trig);
            spi_in_sck = 1'b0;
        end
        repeat (2) @(negedge ep50trig);
        spi_in_ssel = 1'b1;
        repeat (8) @(negedge ep50trig);
    endtask

    initial begin
        wire_hi = '0;
        wire_lo = '0;
        trig = '0;
        rd_addr = '0;
        spi_in_sck = 1'b0;
        spi_in_mosi = 1'b0;
        spi_in_ssel = 1'b1;
        wait_reset_release();

        ////////////////////
        // readback of reset values, then loads
        for (int a = 1; a <= 6; a++) begin
            @(negedge ep50trig);
            rd_addr = 4'(a);
        end
        for (int a = 1; a <= 5; a++)
            load_param(a, $random(seed));
        load_param(spindle_pkg::addr_tick_half, 32'd4 + ($random(seed) & 7));
        load_param(spindle_pkg::addr_gamma_dyn, 32'd64);
        load_param(spindle_pkg::addr_gamma_sta, 32'd96);
        load_param(spindle_pkg::addr_lce_rest, 32'd1000);
        load_param(spindle_pkg::addr_len_mode, 32'd0);

        // tick rate, short period also drops ticks at the sender
        load_param(spindle_pkg::addr_tick_half, 32'd4);
        wait_ticks(40);
        load_param(spindle_pkg::addr_tick_half, 32'd9);
        wait_ticks(6);

        ////////////////////
        // length frames
        repeat (4) send_frame($random(seed), 32);
        send_frame(32'h0000_0500, 32);
        wait_ticks(3);
        send_frame($random(seed), 20);  // must be ignored
        wait_ticks(3);

        // host length below and above rest, clamping included
        load_param(spindle_pkg::addr_host_len, 32'd900);
        load_param(spindle_pkg::addr_len_mode, 32'd1);
        wait_ticks(4);
        load_param(spindle_pkg::addr_host_len, 32'd1500);
        wait_ticks(4);
        wait_sender_idle();
        wait_ticks(2);
        wait_sender_idle();

        errs = dut_i.chk_i.err_cnt;
        $display("assertion errors: %0d, timeouts: %0d", errs, timeouts);
        if (errs == 0 && timeouts == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        #5ms;
        $display("simulation limit reached before the test finished");
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- compile.f
logic/spindle_pkg.sv
logic/param_bank.sv
logic/tick_divider.sv
logic/spi_length_receiver.sv
logic/spi_rate_sender.sv
logic/spindle_afferent.sv
logic/spindle_board.sv
tb/tb_clock_gen.sv
tb/spindle_board_checker.sv
tb/spindle_board_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the testbench with Verilator, exit status follows the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f \
    --top-module spindle_board_tb -o spindle_board_sim \
    && ./obj_dir/spindle_board_sim | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
